// File: project.f
verilog/dcache_pkg.sv
verilog/cache_req_if.sv
verilog/tlb_lookup.sv
verilog/access_queue.sv
verilog/aq_system.sv
verilog/cache_bank.sv
verilog/dcache_top.sv
sim/dcache_sva.sv
sim/dcache_tb.sv

// File: sim/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb import dcache_pkg::*;;

   localparam logic [VPN_W-1:0] PAGE_RW0  = 20'h00010;
   localparam logic [VPN_W-1:0] PAGE_RW1  = 20'h00021;
   localparam logic [VPN_W-1:0] PAGE_RO   = 20'h00033;
   localparam logic [VPN_W-1:0] PAGE_NP   = 20'h00047;
   localparam logic [VPN_W-1:0] PAGE_NONE = 20'h000ab;

   logic                         clk;
   logic                         arst_n_i;
   logic                         rd_valid_i;
   logic [VADDR_W-1:0]           rd_vaddr_i;
   logic [PTCID_W-1:0]           rd_ptcid_i;
   logic                         wb_valid_i;
   logic [VADDR_W-1:0]           wb_vaddr_i;
   logic [LINE_W-1:0]            wb_data_i;
   logic [PTCID_W-1:0]           wb_ptcid_i;
   logic [TLB_ENTRIES*VPN_W-1:0] vp_i;
   logic [TLB_ENTRIES*VPN_W-1:0] pf_i;
   logic [TLB_ENTRIES-1:0]       entry_v_i;
   logic [TLB_ENTRIES-1:0]       entry_p_i;
   logic [TLB_ENTRIES-1:0]       entry_rw_i;
   logic                         tlb_hit_r_o;
   logic                         tlb_miss_r_o;
   logic                         tlb_pe_r_o;
   logic                         tlb_hit_wb_o;
   logic                         tlb_miss_wb_o;
   logic                         tlb_pe_wb_o;
   logic                         cache_valid_o;
   logic                         cache_miss_o;
   logic [LINE_W-1:0]            data_o;
   logic [PTCID_W-1:0]           ptcid_o;
   logic                         aq_isempty_o;
   logic                         rdaq_isfull_o;
   logic                         wbaq_isfull_o;

   // TLB image and line memory model indexed by {index, bank}
   logic [VPN_W-1:0]        tlb_vpn    [TLB_ENTRIES];
   logic [VPN_W-1:0]        tlb_pf     [TLB_ENTRIES];
   logic [TAG_W-1:0]        model_tag  [2*BANK_LINES];
   logic [LINE_W-1:0]       model_line [2*BANK_LINES];
   logic [2*BANK_LINES-1:0] model_v;
   bit                      exp_hit    [$];
   logic [LINE_W-1:0]       exp_data   [$];
   logic [PTCID_W-1:0]      exp_ptcid  [$];
   int                      seed = 22;
   int                      resp_count = 0;

   dcache_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic report_failure(input bit wrong_value, input string msg);
      if (wrong_value) begin
         $display("[ERROR] %0t ns: %s", $time, msg);
      end else begin
         $display("%0t ns: %s", $time, msg);
      end
      $display("** FAIL **");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic load_tlb_image();
      // Unused entries point at the unmapped page but stay invalid
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         tlb_vpn[i] = PAGE_NONE;
         tlb_pf[i]  = 20'h12347;
      end
      tlb_vpn[0] = PAGE_RW0;
      tlb_pf[0]  = 20'h12340;
      tlb_vpn[1] = PAGE_RW1;
      tlb_pf[1]  = 20'h12345;
      tlb_vpn[2] = PAGE_RO;
      tlb_pf[2]  = 20'h12342;
      tlb_vpn[3] = PAGE_NP;
      tlb_pf[3]  = 20'h12343;
      entry_v_i  = 8'b0000_1111;
      entry_p_i  = 8'b1111_0111;
      entry_rw_i = 8'b1111_1011;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         vp_i[i*VPN_W +: VPN_W] = tlb_vpn[i];
         pf_i[i*VPN_W +: VPN_W] = tlb_pf[i];
      end
   endtask

   function automatic tlb_status_e translate(input logic [VADDR_W-1:0] va, input bit is_write,
                                             output logic [PADDR_W-1:0] pa);
      pa = '0;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         if (entry_v_i[i] && tlb_vpn[i] == va[VADDR_W-1 -: VPN_W]) begin
            pa = {tlb_pf[i][PADDR_W-PAGE_OFS_W-1:0], va[PAGE_OFS_W-1:0]};
            if (!entry_p_i[i] || (is_write && !entry_rw_i[i])) return TLB_PROT;
            return TLB_HIT;
         end
      end
      return TLB_MISS;
   endfunction

   // One cycle of requests followed by the TLB flag check and model update
   task automatic issue(input bit do_rd, input logic [VADDR_W-1:0] rva,
                        input bit do_wb, input logic [VADDR_W-1:0] wva);
      tlb_status_e        rst;
      tlb_status_e        wst;
      logic [PADDR_W-1:0] rpa;
      logic [PADDR_W-1:0] wpa;
      logic [4:0]         slot;
      logic [PTCID_W-1:0] rid;
      logic [LINE_W-1:0]  wdata;
      rid = PTCID_W'($random(seed));
      wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
      rd_valid_i = do_rd;
      rd_vaddr_i = rva;
      rd_ptcid_i = rid;
      wb_valid_i = do_wb;
      wb_vaddr_i = wva;
      wb_data_i  = wdata;
      wb_ptcid_i = PTCID_W'($random(seed));
      @(negedge clk);
      rd_valid_i = 1'b0;
      wb_valid_i = 1'b0;
      rst = translate(rva, 1'b0, rpa);
      wst = translate(wva, 1'b1, wpa);
      assert ({tlb_hit_r_o, tlb_miss_r_o, tlb_pe_r_o} == {do_rd && rst == TLB_HIT,
              do_rd && rst == TLB_MISS, do_rd && rst == TLB_PROT})
         else report_failure(1, $sformatf("read TLB flags wrong for vaddr %h", rva));
      assert ({tlb_hit_wb_o, tlb_miss_wb_o, tlb_pe_wb_o} == {do_wb && wst == TLB_HIT,
              do_wb && wst == TLB_MISS, do_wb && wst == TLB_PROT})
         else report_failure(1, $sformatf("write-back TLB flags wrong for vaddr %h", wva));
      if (do_wb && wst == TLB_HIT) begin
         slot = wpa[BANK_BIT +: INDEX_W+1];
         model_v[slot]    = 1'b1;
         model_tag[slot]  = wpa[TAG_LSB +: TAG_W];
         model_line[slot] = wdata;
      end
      if (do_rd && rst == TLB_HIT) begin
         slot = rpa[BANK_BIT +: INDEX_W+1];
         exp_hit.push_back(model_v[slot] && model_tag[slot] == rpa[TAG_LSB +: TAG_W]);
         exp_data.push_back(model_line[slot]);
         exp_ptcid.push_back(rid);
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_hit.size() != 0 || !aq_isempty_o) begin
         @(negedge clk);
         n++;
         if (n > 100) report_failure(0, "read responses did not arrive within 100 cycles");
      end
   endtask

   // Responses must arrive in read-request order
   always @(negedge clk) begin
      if (cache_valid_o || cache_miss_o) begin
         assert (exp_hit.size() != 0)
            else report_failure(0, "read response arrived with no read outstanding");
         assert (cache_valid_o == exp_hit[0])
            else report_failure(1, $sformatf("hit %b, expected %b", cache_valid_o, exp_hit[0]));
         assert (ptcid_o == exp_ptcid[0])
            else report_failure(1, $sformatf("ptcid %h, expected %h", ptcid_o, exp_ptcid[0]));
         if (exp_hit[0]) begin
            assert (data_o == exp_data[0])
               else report_failure(1, $sformatf("data %h, expected %h", data_o, exp_data[0]));
         end
         exp_hit.delete(0);
         exp_data.delete(0);
         exp_ptcid.delete(0);
         resp_count++;
      end
   end

   always @(negedge clk) begin
      if (uut.u_sva.fail_count != 0) begin
         report_failure(0, "a bound assertion on the DUT outputs failed");
      end
   end

   task automatic reset_state();
      assert ({tlb_hit_r_o, tlb_miss_r_o, tlb_pe_r_o, tlb_hit_wb_o, tlb_miss_wb_o, tlb_pe_wb_o,
               cache_valid_o, cache_miss_o, rdaq_isfull_o, wbaq_isfull_o} == '0 && aq_isempty_o)
         else report_failure(1, "outputs not idle after reset");
   endtask

   task automatic unmapped_read();
      int start;
      start = resp_count;
      issue(1'b1, {PAGE_NONE, 12'h450}, 1'b0, '0);
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         assert (!tlb_miss_r_o && aq_isempty_o && resp_count == start)
            else report_failure(1, "activity after a read TLB miss");
      end
   endtask

   task automatic protection_faults();
      issue(1'b0, '0, 1'b1, {PAGE_RO, 12'h340});
      issue(1'b1, {PAGE_NP, 12'h340}, 1'b0, '0);
      issue(1'b1, {PAGE_RO, 12'h340}, 1'b0, '0);
      drain();
   endtask

   task automatic write_then_read();
      logic [PAGE_OFS_W-1:0] ofs;
      logic [VADDR_W-1:0]    va;
      for (int i = 0; i < 8; i++) begin
         ofs = PAGE_OFS_W'($random(seed));
         ofs[BANK_BIT] = i[0];
         va = {(i[1] ? PAGE_RW1 : PAGE_RW0), ofs};
         issue(1'b0, '0, 1'b1, va);
         issue(1'b1, va, 1'b0, '0);
         drain();
      end
   endtask

   task automatic index_conflict();
      issue(1'b1, {PAGE_RO, 12'h5a0}, 1'b0, '0);
      issue(1'b0, '0, 1'b1, {PAGE_RW0, 12'h020});
      issue(1'b0, '0, 1'b1, {PAGE_RW1, 12'h020});
      issue(1'b1, {PAGE_RW0, 12'h020}, 1'b0, '0);
      issue(1'b1, {PAGE_RW1, 12'h020}, 1'b0, '0);
      drain();
   endtask

   // Writes use index 8 to 15 and reads index 0 to 7
   task automatic queue_backpressure();
      bit                 saw_full;
      logic [VADDR_W-1:0] rva;
      logic [VADDR_W-1:0] wva;
      saw_full = 1'b0;
      for (int n = 0; n < 30; n++) begin
         if (rdaq_isfull_o) saw_full = 1'b1;
         rva = {(n[0] ? PAGE_RW1 : PAGE_RW0), PAGE_OFS_W'($random(seed)) & 12'heff};
         wva = {(n[1] ? PAGE_RW1 : PAGE_RW0), PAGE_OFS_W'($random(seed)) | 12'h100};
         issue(!rdaq_isfull_o, rva, !wbaq_isfull_o, wva);
      end
      assert (saw_full) else report_failure(0, "read queue never reported full under load");
      drain();
   endtask

   initial begin
      arst_n_i   = 1'b0;
      rd_valid_i = 1'b0;
      rd_vaddr_i = '0;
      rd_ptcid_i = '0;
      wb_valid_i = 1'b0;
      wb_vaddr_i = '0;
      wb_data_i  = '0;
      wb_ptcid_i = '0;
      model_v    = '0;
      load_tlb_image();
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n_i = 1'b1;
      reset_state();
      unmapped_read();
      protection_faults();
      write_then_read();
      index_conflict();
      queue_backpressure();
      if (exp_hit.size() == 0 && aq_isempty_o && uut.u_sva.fail_count == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         report_failure(0, "reads outstanding or a bound assertion failed at end of run");
      end
   end

endmodule

`default_nettype wire

// File: sim/dcache_sva.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_sva (
   input wire logic clk,
   input wire logic arst_n_i,
   input wire logic rd_valid_i,
   input wire logic wb_valid_i,
   input wire logic tlb_hit_r_i,
   input wire logic tlb_miss_r_i,
   input wire logic tlb_pe_r_i,
   input wire logic tlb_hit_wb_i,
   input wire logic tlb_miss_wb_i,
   input wire logic tlb_pe_wb_i,
   input wire logic cache_valid_i,
   input wire logic cache_miss_i,
   input wire logic aq_isempty_i
);

   int fail_count = 0;

   resp_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(cache_valid_i && cache_miss_i))
      else begin
         $error("cache_valid_o and cache_miss_o high in the same cycle");
         fail_count++;
      end

   // Exactly one flag follows each sampled request
   rd_flags_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0({tlb_hit_r_i, tlb_miss_r_i, tlb_pe_r_i}) &&
      $onehot({tlb_hit_r_i, tlb_miss_r_i, tlb_pe_r_i}) == $past(rd_valid_i))
      else begin
         $error("read port TLB flags do not match the sampled request");
         fail_count++;
      end

   wb_flags_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0({tlb_hit_wb_i, tlb_miss_wb_i, tlb_pe_wb_i}) &&
      $onehot({tlb_hit_wb_i, tlb_miss_wb_i, tlb_pe_wb_i}) == $past(wb_valid_i))
      else begin
         $error("write-back port TLB flags do not match the sampled request");
         fail_count++;
      end

   // A response needs a request in the bank one cycle earlier
   no_resp_when_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
      ($past(aq_isempty_i, 1) && $past(aq_isempty_i, 2)) |-> !(cache_valid_i || cache_miss_i))
      else begin
         $error("read response while both access queues were empty");
         fail_count++;
      end

endmodule

bind dcache_top dcache_sva u_sva (
   .clk (clk), .arst_n_i (arst_n_i),
   .rd_valid_i (rd_valid_i), .wb_valid_i (wb_valid_i),
   .tlb_hit_r_i (tlb_hit_r_o), .tlb_miss_r_i (tlb_miss_r_o), .tlb_pe_r_i (tlb_pe_r_o),
   .tlb_hit_wb_i (tlb_hit_wb_o), .tlb_miss_wb_i (tlb_miss_wb_o), .tlb_pe_wb_i (tlb_pe_wb_o),
   .cache_valid_i (cache_valid_o), .cache_miss_i (cache_miss_o),
   .aq_isempty_i (aq_isempty_o)
);

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; (
   input  wire logic                         clk,
   input  wire logic                         arst_n_i,
   input  wire logic                         rd_valid_i,
   input  wire logic [VADDR_W-1:0]           rd_vaddr_i,
   input  wire logic [PTCID_W-1:0]           rd_ptcid_i,
   input  wire logic                         wb_valid_i,
   input  wire logic [VADDR_W-1:0]           wb_vaddr_i,
   input  wire logic [LINE_W-1:0]            wb_data_i,
   input  wire logic [PTCID_W-1:0]           wb_ptcid_i,
   input  wire logic [TLB_ENTRIES*VPN_W-1:0] vp_i,
   input  wire logic [TLB_ENTRIES*VPN_W-1:0] pf_i,
   input  wire logic [TLB_ENTRIES-1:0]       entry_v_i,
   input  wire logic [TLB_ENTRIES-1:0]       entry_p_i,
   input  wire logic [TLB_ENTRIES-1:0]       entry_rw_i,
   output logic                              tlb_hit_r_o,
   output logic                              tlb_miss_r_o,
   output logic                              tlb_pe_r_o,
   output logic                              tlb_hit_wb_o,
   output logic                              tlb_miss_wb_o,
   output logic                              tlb_pe_wb_o,
   output logic                              cache_valid_o,
   output logic                              cache_miss_o,
   output logic [LINE_W-1:0]                 data_o,
   output logic [PTCID_W-1:0]                ptcid_o,
   output logic                              aq_isempty_o,
   output logic                              rdaq_isfull_o,
   output logic                              wbaq_isfull_o
);

   tlb_status_e        rd_status;
   tlb_status_e        wb_status;
   logic               rd_status_v;
   logic               wb_status_v;
   logic               rd_enq;
   logic               wb_enq;
   req_t               rd_req;
   req_t               wb_req;
   logic [1:0]         bank_hit;
   logic [1:0]         bank_miss;
   logic [LINE_W-1:0]  bank_data  [2];
   logic [PTCID_W-1:0] bank_ptcid [2];
   logic               odd_resp;

   cache_req_if u_req_if ();

   // Reads carry no line data
   tlb_lookup u_rd_tlb (
      .clk (clk), .arst_n_i (arst_n_i),
      .valid_i (rd_valid_i), .op_i (OP_READ), .vaddr_i (rd_vaddr_i),
      .data_i ('0), .ptcid_i (rd_ptcid_i),
      .vp_i (vp_i), .pf_i (pf_i),
      .entry_v_i (entry_v_i), .entry_p_i (entry_p_i), .entry_rw_i (entry_rw_i),
      .status_o (rd_status), .status_valid_o (rd_status_v),
      .enq_o (rd_enq), .req_o (rd_req)
   );

   tlb_lookup u_wb_tlb (
      .clk (clk), .arst_n_i (arst_n_i),
      .valid_i (wb_valid_i), .op_i (OP_WRITE), .vaddr_i (wb_vaddr_i),
      .data_i (wb_data_i), .ptcid_i (wb_ptcid_i),
      .vp_i (vp_i), .pf_i (pf_i),
      .entry_v_i (entry_v_i), .entry_p_i (entry_p_i), .entry_rw_i (entry_rw_i),
      .status_o (wb_status), .status_valid_o (wb_status_v),
      .enq_o (wb_enq), .req_o (wb_req)
   );

   aq_system u_aq_system (
      .clk (clk), .arst_n_i (arst_n_i),
      .rd_enq_i (rd_enq), .rd_req_i (rd_req),
      .wb_enq_i (wb_enq), .wb_req_i (wb_req),
      .req (u_req_if.source),
      .aq_isempty_o (aq_isempty_o),
      .rdaq_isfull_o (rdaq_isfull_o),
      .wbaq_isfull_o (wbaq_isfull_o)
   );

   for (genvar b = 0; b < 2; b++) begin : g_bank
      cache_bank #(.BANK_ID(b)) u_bank (
         .clk (clk), .arst_n_i (arst_n_i),
         .req (u_req_if.sink),
         .hit_o (bank_hit[b]), .miss_o (bank_miss[b]),
         .data_o (bank_data[b]), .ptcid_o (bank_ptcid[b])
      );
   end

   assign tlb_hit_r_o   = rd_status_v && rd_status == TLB_HIT;
   assign tlb_miss_r_o  = rd_status_v && rd_status == TLB_MISS;
   assign tlb_pe_r_o    = rd_status_v && rd_status == TLB_PROT;
   assign tlb_hit_wb_o  = wb_status_v && wb_status == TLB_HIT;
   assign tlb_miss_wb_o = wb_status_v && wb_status == TLB_MISS;
   assign tlb_pe_wb_o   = wb_status_v && wb_status == TLB_PROT;

   // At most one bank answers per cycle
   assign odd_resp      = bank_hit[1] || bank_miss[1];
   assign cache_valid_o = |bank_hit;
   assign cache_miss_o  = |bank_miss;
   assign data_o        = odd_resp ? bank_data[1] : bank_data[0];
   assign ptcid_o       = odd_resp ? bank_ptcid[1] : bank_ptcid[0];

endmodule

`default_nettype wire

// File: verilog/cache_bank.sv
`timescale 1ns/1ns
`default_nettype none

module cache_bank import dcache_pkg::*; #(
   parameter int BANK_ID = 0
) (
   input  wire logic             clk,
   input  wire logic             arst_n_i,
   cache_req_if.sink             req,
   output logic                  hit_o,
   output logic                  miss_o,
   output logic [LINE_W-1:0]     data_o,
   output logic [PTCID_W-1:0]    ptcid_o
);

   logic [TAG_W-1:0]    tag_mem  [BANK_LINES];
   logic [LINE_W-1:0]   line_mem [BANK_LINES];
   logic [BANK_LINES-1:0] line_v;
   logic [INDEX_W-1:0]  idx;
   logic [TAG_W-1:0]    tag;
   logic                accept;
   logic                rd_acc;
   logic                wr_acc;
   logic                tag_match;

   assign idx    = req.paddr[INDEX_LSB +: INDEX_W];
   assign tag    = req.paddr[TAG_LSB +: TAG_W];
   assign accept = req.valid && req.paddr[BANK_BIT] == BANK_ID[0];
   assign rd_acc = accept && req.op == OP_READ;
   assign wr_acc = accept && req.op == OP_WRITE;

   assign tag_match = line_v[idx] && tag_mem[idx] == tag;

   // Whole-line allocate on write-back
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         line_v <= '0;
      end else if (wr_acc) begin
         line_v[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_acc) begin
         tag_mem[idx]  <= tag;
         line_mem[idx] <= req.data;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hit_o  <= 1'b0;
         miss_o <= 1'b0;
      end else begin
         hit_o  <= rd_acc && tag_match;
         miss_o <= rd_acc && !tag_match;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_acc) begin
         data_o  <= line_mem[idx];
         ptcid_o <= req.ptcid;
      end
   end

endmodule

`default_nettype wire

// File: verilog/aq_system.sv
`timescale 1ns/1ns
`default_nettype none

module aq_system import dcache_pkg::*; (
   input  wire logic   clk,
   input  wire logic   arst_n_i,
   input  wire logic   rd_enq_i,
   input  req_t        rd_req_i,
   input  wire logic   wb_enq_i,
   input  req_t        wb_req_i,
   cache_req_if.source req,
   output logic        aq_isempty_o,
   output logic        rdaq_isfull_o,
   output logic        wbaq_isfull_o
);

   req_t rd_head;
   req_t wb_head;
   req_t sel_head;
   logic rd_empty;
   logic wb_empty;
   logic rd_pop;
   logic wb_pop;

   access_queue u_rd_aq (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .enq_i    (rd_enq_i),
      .req_i    (rd_req_i),
      .pop_i    (rd_pop),
      .head_o   (rd_head),
      .empty_o  (rd_empty),
      .full_o   (rdaq_isfull_o)
   );

   access_queue u_wb_aq (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .enq_i    (wb_enq_i),
      .req_i    (wb_req_i),
      .pop_i    (wb_pop),
      .head_o   (wb_head),
      .empty_o  (wb_empty),
      .full_o   (wbaq_isfull_o)
   );

   // Write-backs go first
   assign wb_pop   = !wb_empty;
   assign rd_pop   = wb_empty && !rd_empty;
   assign sel_head = wb_empty ? rd_head : wb_head;

   assign req.valid = wb_pop || rd_pop;
   assign req.op    = sel_head.op;
   assign req.paddr = sel_head.paddr;
   assign req.data  = sel_head.data;
   assign req.ptcid = sel_head.ptcid;

   assign aq_isempty_o = wb_empty && rd_empty;

endmodule

`default_nettype wire

// File: verilog/access_queue.sv
`timescale 1ns/1ns
`default_nettype none

module access_queue import dcache_pkg::*; (
   input  wire logic clk,
   input  wire logic arst_n_i,
   input  wire logic enq_i,
   input  req_t      req_i,
   input  wire logic pop_i,
   output req_t      head_o,
   output logic      empty_o,
   output logic      full_o
);

   req_t                mem [AQ_DEPTH];
   logic [AQ_PTR_W-1:0] wr_ptr;
   logic [AQ_PTR_W-1:0] rd_ptr;
   logic [AQ_PTR_W:0]   count;
   logic                at_depth;
   logic                do_enq;
   logic                do_pop;

   assign at_depth = count == AQ_DEPTH;
   assign empty_o  = count == 0;
   assign do_enq   = enq_i && !at_depth;
   assign do_pop   = pop_i && !empty_o;

   // Also counts the translated request about to land here
   assign full_o = at_depth || (count == AQ_DEPTH - 1 && enq_i);

   assign head_o = mem[rd_ptr];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + (do_enq ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
      end
   end

   always_ff @(posedge clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= req_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tlb_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_lookup import dcache_pkg::*; (
   input  wire logic                         clk,
   input  wire logic                         arst_n_i,
   input  wire logic                         valid_i,
   input  aq_op_e                            op_i,
   input  wire logic [VADDR_W-1:0]           vaddr_i,
   input  wire logic [LINE_W-1:0]            data_i,
   input  wire logic [PTCID_W-1:0]           ptcid_i,
   input  wire logic [TLB_ENTRIES*VPN_W-1:0] vp_i,
   input  wire logic [TLB_ENTRIES*VPN_W-1:0] pf_i,
   input  wire logic [TLB_ENTRIES-1:0]       entry_v_i,
   input  wire logic [TLB_ENTRIES-1:0]       entry_p_i,
   input  wire logic [TLB_ENTRIES-1:0]       entry_rw_i,
   output tlb_status_e                       status_o,
   output logic                              status_valid_o,
   output logic                              enq_o,
   output req_t                              req_o
);

   logic                 found;
   logic [TLB_IDX_W-1:0] hit_idx;
   logic                 prot;
   tlb_status_e          status_nxt;
   logic [PADDR_W-1:0]   paddr;

   // Lowest matching entry wins
   always_comb begin
      found   = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         if (!found && entry_v_i[i] &&
             vp_i[i*VPN_W +: VPN_W] == vaddr_i[VADDR_W-1 -: VPN_W]) begin
            found   = 1'b1;
            hit_idx = TLB_IDX_W'(i);
         end
      end
   end

   assign prot = !entry_p_i[hit_idx] || (op_i == OP_WRITE && !entry_rw_i[hit_idx]);

   assign status_nxt = !found ? TLB_MISS : (prot ? TLB_PROT : TLB_HIT);

   assign paddr = {pf_i[hit_idx*VPN_W +: FRAME_W], vaddr_i[PAGE_OFS_W-1:0]};

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         status_valid_o <= 1'b0;
         status_o       <= TLB_HIT;
         enq_o          <= 1'b0;
      end else begin
         status_valid_o <= valid_i;
         status_o       <= status_nxt;
         enq_o          <= valid_i && status_nxt == TLB_HIT;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_i) begin
         req_o <= '{op: op_i, paddr: paddr, data: data_i, ptcid: ptcid_i};
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_req_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cache_req_if import dcache_pkg::*;;

   logic                 valid;
   aq_op_e               op;
   logic [PADDR_W-1:0]   paddr;
   logic [LINE_W-1:0]    data;
   logic [PTCID_W-1:0]   ptcid;

   modport source (
      output valid, op, paddr, data, ptcid
   );

   // Both banks listen and the bank bit picks the taker
   modport sink (
      input valid, op, paddr, data, ptcid
   );

endinterface

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   // Address and size constants
   localparam int VADDR_W     = 32;
   localparam int PADDR_W     = 15;
   localparam int PAGE_OFS_W  = 12;
   localparam int FRAME_W     = PADDR_W - PAGE_OFS_W;
   localparam int TLB_ENTRIES = 8;
   localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
   localparam int VPN_W       = 20;
   localparam int LINE_W      = 128;
   localparam int BANK_BIT    = 4;
   localparam int INDEX_W     = 4;
   localparam int INDEX_LSB   = BANK_BIT + 1;
   localparam int TAG_W       = 6;
   localparam int TAG_LSB     = INDEX_LSB + INDEX_W;
   localparam int BANK_LINES  = 1 << INDEX_W;
   localparam int PTCID_W     = 7;
   localparam int AQ_DEPTH    = 4;
   localparam int AQ_PTR_W    = $clog2(AQ_DEPTH);

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } aq_op_e;

   typedef enum logic [1:0] {
      TLB_HIT  = 2'd0,
      TLB_MISS = 2'd1,
      TLB_PROT = 2'd2
   } tlb_status_e;

   // One translated request as held in an access queue
   typedef struct packed {
      aq_op_e               op;
      logic [PADDR_W-1:0]   paddr;
      logic [LINE_W-1:0]    data;
      logic [PTCID_W-1:0]   ptcid;
   } req_t;

endpackage

`default_nettype wire
